// ==== src/vec_pkg.sv ====
package vec_pkg;

  // datapath sizes
  localparam int ELEN      = 32;
  localparam int VLMAX     = 4;
  localparam int LANES     = 2;
  localparam int NUM_VREGS = 32;

  // major opcode and funct3 classes
  localparam logic [6:0] OPV   = 7'b1010111;
  localparam logic [2:0] OPIVV = 3'b000;
  localparam logic [2:0] OPMVV = 3'b010;
  localparam logic [2:0] OPIVI = 3'b011;
  localparam logic [2:0] OPIVX = 3'b100;
  localparam logic [2:0] OPMVX = 3'b110;

  // funct6 codes
  localparam logic [5:0] F6_VADD        = 6'b000000;
  localparam logic [5:0] F6_VSUB        = 6'b000010;
  localparam logic [5:0] F6_VMINU       = 6'b000100;
  localparam logic [5:0] F6_VMAXU       = 6'b000110;
  localparam logic [5:0] F6_VAND        = 6'b001001;
  localparam logic [5:0] F6_VOR         = 6'b001010;
  localparam logic [5:0] F6_VXOR        = 6'b001011;
  localparam logic [5:0] F6_VSLIDE1UP   = 6'b001110;
  localparam logic [5:0] F6_VSLIDE1DOWN = 6'b001111;
  localparam logic [5:0] F6_VMUNARY0    = 6'b010100;
  localparam logic [5:0] F6_VMV         = 6'b010111;

  // vs1 field selecting vid.v inside VMUNARY0
  localparam logic [4:0] VID_VS1 = 5'b10001;

  typedef logic [ELEN-1:0]              elem_t;
  typedef logic [$clog2(NUM_VREGS)-1:0] vreg_t;
  typedef logic [$clog2(VLMAX)-1:0]     eidx_t;
  typedef logic [2:0]                   vl_t;
  // element offset, wide enough for -1 (wraps to 7) and VLMAX
  typedef logic [2:0]                   vofs_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_MINU, ALU_MAXU, ALU_PASSB
  } valu_op_e;

  typedef enum logic [1:0] {SRC_VS1, SRC_XS1, SRC_IMM} opnd_src_e;

  typedef enum logic [1:0] {OFS_NORMAL, OFS_PLUS1, OFS_MINUS1} offset_src_e;

  typedef struct packed {
    logic [31:0] instr;
    elem_t       xs1;
    vl_t         vl;
  } vec_cmd_t;

  typedef struct packed {
    valu_op_e    op;
    vreg_t       vd;
    vreg_t       vs1;
    vreg_t       vs2;
    opnd_src_e   opnd_src;
    offset_src_e offset_src;
    logic        masked;
    logic        is_vid;
    elem_t       b_scalar;
    vl_t         vl;
  } uop_t;

  typedef struct packed {
    valu_op_e                op;
    vreg_t                   vd;
    eidx_t                   eidx;
    elem_t [LANES-1:0]       a;
    elem_t [LANES-1:0]       b;
    logic  [LANES-1:0]       wen;
    logic  [LANES-1:0]       fill;
    elem_t                   fill_val;
    logic                    last;
  } exec_req_t;

  typedef struct packed {
    vreg_t vd;
    eidx_t eidx;
    elem_t data0;
    elem_t data1;
    logic  wen0;
    logic  wen1;
    logic  last;
  } result_t;

endpackage

// ==== src/vec_pipe_slot.sv ====
`timescale 1ns/1ps

module vec_pipe_slot #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out
);

  // takes a new entry when empty or when draining this cycle
  assign in_ready = ~out_valid | out_ready;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (in_valid && in_ready) begin
      out <= in;
    end
  end

endmodule

// ==== src/vec_instr_decoder.sv ====
`timescale 1ns/1ps

module vec_instr_decoder (
  input  logic [31:0]    instr,
  input  vec_pkg::elem_t xs1,
  input  vec_pkg::vl_t   vl,
  output vec_pkg::uop_t  uop,
  output logic           illegal
);
  import vec_pkg::*;

  logic [5:0] funct6;
  logic [2:0] funct3;
  logic       vm;
  logic       legal;
  elem_t      imm_sext;

  assign funct6   = instr[31:26];
  assign vm       = instr[25];
  assign funct3   = instr[14:12];
  assign imm_sext = {{(ELEN-5){instr[19]}}, instr[19:15]};

  always_comb begin
    legal          = 1'b0;
    uop.op         = ALU_PASSB;
    uop.vd         = instr[11:7];
    uop.vs1        = instr[19:15];
    uop.vs2        = instr[24:20];
    uop.opnd_src   = (funct3 == OPIVV) ? SRC_VS1 : (funct3 == OPIVI) ? SRC_IMM : SRC_XS1;
    uop.offset_src = OFS_NORMAL;
    uop.masked     = ~vm;
    uop.is_vid     = 1'b0;
    uop.b_scalar   = (funct3 == OPIVI) ? imm_sext : xs1;
    uop.vl         = vl;

    if (funct3 == OPIVV || funct3 == OPIVX || funct3 == OPIVI) begin
      case (funct6)
        F6_VADD:  begin uop.op = ALU_ADD;  legal = 1'b1; end
        F6_VAND:  begin uop.op = ALU_AND;  legal = 1'b1; end
        F6_VOR:   begin uop.op = ALU_OR;   legal = 1'b1; end
        F6_VXOR:  begin uop.op = ALU_XOR;  legal = 1'b1; end
        // no vi form for these
        F6_VSUB:  begin uop.op = ALU_SUB;  legal = (funct3 != OPIVI); end
        F6_VMINU: begin uop.op = ALU_MINU; legal = (funct3 != OPIVI); end
        F6_VMAXU: begin uop.op = ALU_MAXU; legal = (funct3 != OPIVI); end
        // vmv.v.x only, vm=0 would be vmerge
        F6_VMV:   legal = (funct3 == OPIVX) && vm && (uop.vs2 == '0);
        default:  legal = 1'b0;
      endcase
    end else if (funct3 == OPMVX) begin
      if (funct6 == F6_VSLIDE1UP) begin
        uop.offset_src = OFS_MINUS1;
        legal          = 1'b1;
      end else if (funct6 == F6_VSLIDE1DOWN) begin
        uop.offset_src = OFS_PLUS1;
        legal          = 1'b1;
      end
    end else if (funct3 == OPMVV) begin
      uop.is_vid = 1'b1;
      legal      = (funct6 == F6_VMUNARY0) && (uop.vs1 == VID_VS1) && (uop.vs2 == '0);
    end

    if (instr[6:0] != OPV) begin
      legal = 1'b0;
    end
  end

  assign illegal = ~legal;

endmodule

// ==== src/vec_regfile.sv ====
`timescale 1ns/1ps

module vec_regfile (
  input  logic                                CLK,
  input  logic                                nRST,
  input  vec_pkg::vreg_t                      vs1_addr,
  input  vec_pkg::vofs_t [vec_pkg::LANES-1:0] vs1_ofs,
  input  vec_pkg::vreg_t                      vs2_addr,
  input  vec_pkg::vofs_t [vec_pkg::LANES-1:0] vs2_ofs,
  output vec_pkg::elem_t [vec_pkg::LANES-1:0] vs1_data,
  output vec_pkg::elem_t [vec_pkg::LANES-1:0] vs2_data,
  output logic           [vec_pkg::VLMAX-1:0] v0_mask,
  input  vec_pkg::vreg_t                      wr_vd,
  input  vec_pkg::eidx_t                      wr_idx,
  input  vec_pkg::elem_t [vec_pkg::LANES-1:0] wr_data,
  input  logic           [vec_pkg::LANES-1:0] wr_en
);
  import vec_pkg::*;

  elem_t [VLMAX-1:0] regs [NUM_VREGS];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int r = 0; r < NUM_VREGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int l = 0; l < LANES; l++) begin
        if (wr_en[l]) begin
          regs[wr_vd][wr_idx + eidx_t'(l)] <= wr_data[l];
        end
      end
    end
  end

  // out of range offsets read as zero
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      vs1_data[l] = (vs1_ofs[l] >= vofs_t'(VLMAX)) ? '0 : regs[vs1_addr][vs1_ofs[l][1:0]];
      vs2_data[l] = (vs2_ofs[l] >= vofs_t'(VLMAX)) ? '0 : regs[vs2_addr][vs2_ofs[l][1:0]];
    end
    for (int e = 0; e < VLMAX; e++) begin
      v0_mask[e] = regs[0][e][0];
    end
  end

endmodule

// ==== src/vec_execute.sv ====
`timescale 1ns/1ps

module vec_execute (
  input  vec_pkg::exec_req_t req,
  output vec_pkg::result_t   res
);
  import vec_pkg::*;

  elem_t [LANES-1:0] lane_res;

  function automatic elem_t alu(valu_op_e op, elem_t a, elem_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_MINU: return (a < b) ? a : b;
      ALU_MAXU: return (a > b) ? a : b;
      default:  return b;
    endcase
  endfunction

  // boundary lanes of a slide take the scalar
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      if (req.fill[l]) begin
        lane_res[l] = req.fill_val;
      end else begin
        lane_res[l] = alu(req.op, req.a[l], req.b[l]);
      end
    end
  end

  assign res.vd    = req.vd;
  assign res.eidx  = req.eidx;
  assign res.data0 = lane_res[0];
  assign res.data1 = lane_res[1];
  assign res.wen0  = req.wen[0];
  assign res.wen1  = req.wen[1];
  assign res.last  = req.last;

endmodule

// ==== src/vec_result.sv ====
`timescale 1ns/1ps

module vec_result (
  input  logic                                CLK,
  input  logic                                nRST,
  input  logic                                in_valid,
  output logic                                in_ready,
  input  vec_pkg::result_t                    in,
  output logic                                res_valid,
  input  logic                                res_ready,
  output vec_pkg::result_t                    res,
  output logic                                done,
  output vec_pkg::vreg_t                      wr_vd,
  output vec_pkg::eidx_t                      wr_idx,
  output vec_pkg::elem_t [vec_pkg::LANES-1:0] wr_data,
  output logic           [vec_pkg::LANES-1:0] wr_en
);
  import vec_pkg::*;

  logic beat_taken;

  vec_pipe_slot #(.payload_t(result_t)) beat_reg (
    .CLK(CLK), .nRST(nRST),
    .in_valid(in_valid), .in_ready(in_ready), .in(in),
    .out_valid(res_valid), .out_ready(res_ready), .out(res)
  );

  assign beat_taken = res_valid & res_ready;

  // write back only on an accepted beat
  assign wr_vd   = res.vd;
  assign wr_idx  = res.eidx;
  assign wr_data = {res.data1, res.data0};
  assign wr_en   = {res.wen1, res.wen0} & {LANES{beat_taken}};

  assign done = beat_taken & res.last;

endmodule

// ==== src/vec_decode_stage.sv ====
`timescale 1ns/1ps

module vec_decode_stage (
  input  logic                                   CLK,
  input  logic                                   nRST,
  input  logic                                   cmd_valid,
  input  vec_pkg::vec_cmd_t                      cmd,
  output logic                                   cmd_ready,
  output logic                                   illegal,
  output logic                                   req_valid,
  input  logic                                   req_ready,
  output vec_pkg::exec_req_t                     req,
  input  logic                                   done,
  output vec_pkg::vreg_t                         vs1_addr,
  output vec_pkg::vofs_t [vec_pkg::LANES-1:0]    vs1_ofs,
  output vec_pkg::vreg_t                         vs2_addr,
  output vec_pkg::vofs_t [vec_pkg::LANES-1:0]    vs2_ofs,
  input  vec_pkg::elem_t [vec_pkg::LANES-1:0]    vs1_data,
  input  vec_pkg::elem_t [vec_pkg::LANES-1:0]    vs2_data,
  input  logic           [vec_pkg::VLMAX-1:0]    v0_mask
);
  import vec_pkg::*;

  uop_t              dec_uop, uop;
  logic              dec_illegal;
  logic              cmd_fire;
  logic              busy, active;
  eidx_t             cnt;
  vofs_t [LANES-1:0] idx;
  logic              last;

  vec_instr_decoder instr_dec (
    .instr(cmd.instr), .xs1(cmd.xs1), .vl(cmd.vl),
    .uop(dec_uop), .illegal(dec_illegal)
  );

  assign cmd_ready = ~busy;
  assign cmd_fire  = cmd_valid & cmd_ready;
  assign req_valid = active;

  // busy holds off the next command until the final beat drains
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy    <= 1'b0;
      active  <= 1'b0;
      cnt     <= '0;
      illegal <= 1'b0;
    end else begin
      illegal <= cmd_fire & dec_illegal;
      if (cmd_fire && !dec_illegal) begin
        busy   <= 1'b1;
        active <= 1'b1;
        cnt    <= '0;
      end else begin
        if (done) begin
          busy <= 1'b0;
        end
        if (req_valid && req_ready) begin
          cnt <= cnt + eidx_t'(LANES);
          if (last) begin
            active <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (cmd_fire && !dec_illegal) begin
      uop <= dec_uop;
    end
  end

  // element indices of this pair
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      idx[l] = vofs_t'(cnt) + vofs_t'(l);
    end
  end

  assign last = (vofs_t'(cnt) + vofs_t'(LANES)) >= uop.vl;

  assign vs1_addr = uop.vs1;
  assign vs2_addr = uop.vs2;
  assign vs1_ofs  = idx;

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      case (uop.offset_src)
        OFS_PLUS1:  vs2_ofs[l] = idx[l] + 3'd1;
        // element 0 wraps to 7, which reads as out of range
        OFS_MINUS1: vs2_ofs[l] = idx[l] - 3'd1;
        default:    vs2_ofs[l] = idx[l];
      endcase
    end
  end

  always_comb begin
    req.op       = uop.op;
    req.vd       = uop.vd;
    req.eidx     = cnt;
    req.fill_val = uop.b_scalar;
    req.last     = last;
    for (int l = 0; l < LANES; l++) begin
      req.a[l] = vs2_data[l];
      if (uop.is_vid) begin
        req.b[l] = elem_t'(idx[l]);
      end else if (uop.offset_src != OFS_NORMAL) begin
        // slides pass the shifted vs2 element
        req.b[l] = vs2_data[l];
      end else if (uop.opnd_src == SRC_VS1) begin
        req.b[l] = vs1_data[l];
      end else begin
        req.b[l] = uop.b_scalar;
      end
      req.wen[l]  = (idx[l] < uop.vl) && (!uop.masked || v0_mask[idx[l][1:0]]);
      req.fill[l] = (uop.offset_src != OFS_NORMAL) && (vs2_ofs[l] >= uop.vl);
    end
  end

endmodule

// ==== src/vec_unit.sv ====
`timescale 1ns/1ps

module vec_unit (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              cmd_valid,
  input  vec_pkg::vec_cmd_t cmd,
  output logic              cmd_ready,
  output logic              res_valid,
  input  logic              res_ready,
  output vec_pkg::result_t  res,
  output logic              illegal
);
  import vec_pkg::*;

  exec_req_t         dec_req, ex_req;
  logic              dec_req_valid, dec_req_ready;
  logic              ex_valid, ex_ready;
  result_t           ex_res;
  logic              done;

  // register file hookup
  vreg_t             vs1_addr, vs2_addr;
  vofs_t [LANES-1:0] vs1_ofs, vs2_ofs;
  elem_t [LANES-1:0] vs1_data, vs2_data;
  logic  [VLMAX-1:0] v0_mask;
  vreg_t             wr_vd;
  eidx_t             wr_idx;
  elem_t [LANES-1:0] wr_data;
  logic  [LANES-1:0] wr_en;

  vec_decode_stage decode0 (
    .CLK(CLK), .nRST(nRST),
    .cmd_valid(cmd_valid), .cmd(cmd), .cmd_ready(cmd_ready), .illegal(illegal),
    .req_valid(dec_req_valid), .req_ready(dec_req_ready), .req(dec_req), .done(done),
    .vs1_addr(vs1_addr), .vs1_ofs(vs1_ofs), .vs2_addr(vs2_addr), .vs2_ofs(vs2_ofs),
    .vs1_data(vs1_data), .vs2_data(vs2_data), .v0_mask(v0_mask)
  );

  // decode to execute register
  vec_pipe_slot #(.payload_t(exec_req_t)) de_slot (
    .CLK(CLK), .nRST(nRST),
    .in_valid(dec_req_valid), .in_ready(dec_req_ready), .in(dec_req),
    .out_valid(ex_valid), .out_ready(ex_ready), .out(ex_req)
  );

  vec_execute execute0 (.req(ex_req), .res(ex_res));

  vec_result result0 (
    .CLK(CLK), .nRST(nRST),
    .in_valid(ex_valid), .in_ready(ex_ready), .in(ex_res),
    .res_valid(res_valid), .res_ready(res_ready), .res(res), .done(done),
    .wr_vd(wr_vd), .wr_idx(wr_idx), .wr_data(wr_data), .wr_en(wr_en)
  );

  vec_regfile regfile0 (
    .CLK(CLK), .nRST(nRST),
    .vs1_addr(vs1_addr), .vs1_ofs(vs1_ofs), .vs2_addr(vs2_addr), .vs2_ofs(vs2_ofs),
    .vs1_data(vs1_data), .vs2_data(vs2_data), .v0_mask(v0_mask),
    .wr_vd(wr_vd), .wr_idx(wr_idx), .wr_data(wr_data), .wr_en(wr_en)
  );

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic CLK,
  output logic nRST
);

  // 40 ns period
  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  initial begin
    nRST = 1'b0;
    repeat (4) @(posedge CLK);
    #1 nRST = 1'b1;
  end

endmodule

// ==== dv/vec_model.svh ====
`ifndef VEC_MODEL_SVH
`define VEC_MODEL_SVH

typedef enum int {
  K_ADD, K_AND, K_OR, K_XOR, K_SUB, K_MINU, K_MAXU, K_SLUP, K_SLDN, K_VMV, K_VID, K_BAD
} kind_e;

logic [31:0] mregs [NUM_VREGS][VLMAX];
result_t     exp_q [$];

function automatic logic [31:0] xorshift(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// form 0 is vv, 1 is vx, 2 is vi
function automatic logic [31:0] encode_instr(input kind_e k, input int form, input logic vm,
                                             input logic [4:0] vd, input logic [4:0] vs1,
                                             input logic [4:0] vs2);
  logic [5:0] f6;
  logic [2:0] f3;
  logic [4:0] r1;
  logic [4:0] r2;
  r1 = vs1;
  r2 = vs2;
  f3 = (form == 0) ? OPIVV : (form == 1) ? OPIVX : OPIVI;
  case (k)
    K_ADD:   f6 = F6_VADD;
    K_AND:   f6 = F6_VAND;
    K_OR:    f6 = F6_VOR;
    K_XOR:   f6 = F6_VXOR;
    K_SUB:   f6 = F6_VSUB;
    K_MINU:  f6 = F6_VMINU;
    K_MAXU:  f6 = F6_VMAXU;
    K_SLUP:  begin f6 = F6_VSLIDE1UP;   f3 = OPMVX; end
    K_SLDN:  begin f6 = F6_VSLIDE1DOWN; f3 = OPMVX; end
    K_VMV:   begin f6 = F6_VMV; f3 = OPIVX; r2 = '0; end
    K_VID:   begin f6 = F6_VMUNARY0; f3 = OPMVV; r1 = VID_VS1; r2 = '0; end
    default: begin f6 = 6'b111111; f3 = OPIVV; end
  endcase
  return {f6, vm, r2, r1, f3, vd, OPV};
endfunction

// expected beats of one instruction from the current model registers
task automatic predict_beats(input kind_e k, input int form, input logic masked,
                             input logic [4:0] vd, input logic [4:0] vs1, input logic [4:0] vs2,
                             input logic [31:0] xs1, input logic [4:0] imm, input int vl);
  logic [31:0]      val [VLMAX];
  logic [VLMAX-1:0] en;
  logic [31:0]      a;
  logic [31:0]      b;
  int               n;
  result_t          beat;
  for (int i = 0; i < VLMAX; i++) begin
    a = mregs[vs2][i];
    b = (form == 0) ? mregs[vs1][i] : (form == 1) ? xs1 : {{27{imm[4]}}, imm};
    case (k)
      K_ADD:   val[i] = a + b;
      K_AND:   val[i] = a & b;
      K_OR:    val[i] = a | b;
      K_XOR:   val[i] = a ^ b;
      K_SUB:   val[i] = a - b;
      K_MINU:  val[i] = (a < b) ? a : b;
      K_MAXU:  val[i] = (a > b) ? a : b;
      K_SLUP:  val[i] = (i == 0) ? xs1 : mregs[vs2][i-1];
      K_SLDN:  val[i] = (i >= vl - 1 || i == VLMAX - 1) ? xs1 : mregs[vs2][i+1];
      K_VMV:   val[i] = xs1;
      default: val[i] = i;
    endcase
    en[i] = (i < vl) && (!masked || mregs[0][i][0]);
  end
  n = (vl == 0) ? 1 : (vl + 1) / 2;
  for (int kk = 0; kk < n; kk++) begin
    beat.vd    = vd;
    beat.eidx  = 2'(2 * kk);
    beat.data0 = val[2*kk];
    beat.data1 = val[2*kk+1];
    beat.wen0  = en[2*kk];
    beat.wen1  = en[2*kk+1];
    beat.last  = (kk == n - 1);
    exp_q.push_back(beat);
  end
endtask

`endif

// ==== dv/vec_unit_tb.sv ====
`timescale 1ns/1ps

module vec_unit_tb;
  import vec_pkg::*;

  localparam int NUM_CMDS   = 400;
  localparam int MAX_CYCLES = NUM_CMDS * 40 + 200;

  logic     CLK, nRST;
  logic     cmd_valid, cmd_ready, res_valid, res_ready, illegal;
  vec_cmd_t cmd;
  result_t  res;

  `include "vec_model.svh"

  // fields of the command being driven
  kind_e       c_kind;
  int          c_form, c_vl;
  logic        c_masked;
  logic [4:0]  c_vd, c_vs1, c_vs2, c_imm;
  logic [31:0] c_xs1, stim_state, ready_state;
  int          cyc = 0;
  logic        inflight = 1'b0;

  tb_clock clk0 (.CLK(CLK), .nRST(nRST));

  vec_unit dut0 (
    .CLK(CLK), .nRST(nRST), .cmd_valid(cmd_valid), .cmd(cmd), .cmd_ready(cmd_ready),
    .res_valid(res_valid), .res_ready(res_ready), .res(res), .illegal(illegal)
  );

  task automatic stop_fail(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      stop_fail("output value mismatch");
    end
  endtask

  function automatic logic [31:0] next_rand();
    stim_state = xorshift(stim_state);
    return stim_state;
  endfunction

  always @(posedge CLK) begin
    cyc <= cyc + 1;
    if (cyc > MAX_CYCLES) begin
      stop_fail("timeout, the run did not finish in time");
    end
  end

  // random output back-pressure holds ready low about 30% of cycles
  initial begin
    res_ready   = 1'b0;
    ready_state = 32'd97 ^ 32'h1234_5678;
    forever begin
      @(posedge CLK);
      #1;
      ready_state = xorshift(ready_state);
      res_ready   = (ready_state % 10) >= 3;
    end
  end

  initial begin
    cmd_valid  = 1'b0;
    cmd        = '0;
    stim_state = 32'd97;
    c_kind     = K_ADD;
    wait (nRST);
    for (int n = 0; n < NUM_CMDS; n++) begin
      @(posedge CLK);
      #1;
      c_kind   = kind_e'(int'(next_rand() % 12));
      c_form   = (c_kind <= K_XOR) ? int'(next_rand() % 3) :
                 (c_kind <= K_MAXU) ? int'(next_rand() % 2) : 1;
      c_masked = (c_kind != K_VMV) && (next_rand() % 2 == 1);
      c_vd     = c_masked ? 5'(1 + next_rand() % 31) : 5'(next_rand() % 32);
      c_vs1    = 5'(next_rand() % 32);
      c_vs2    = 5'(next_rand() % 32);
      if ((c_kind == K_SLUP || c_kind == K_SLDN) && c_vs2 == c_vd) begin
        c_vs2 = c_vd ^ 5'd1;
      end
      c_xs1 = next_rand();
      c_imm = 5'(next_rand() % 32);
      c_vl  = int'(next_rand() % 5);
      // vi carries imm5 in the vs1 field
      cmd.instr = encode_instr(c_kind, c_form, !c_masked, c_vd,
                               (c_form == 2) ? c_imm : c_vs1, c_vs2);
      // random funct6 outside the kept set
      if (c_kind == K_BAD) begin
        cmd.instr[31:26] = 6'b100000 | 6'(next_rand() % 32);
      end
      cmd.xs1   = c_xs1;
      cmd.vl    = 3'(c_vl);
      cmd_valid = 1'b1;
      do @(posedge CLK); while (!cmd_ready);
      #1 cmd_valid = 1'b0;
    end
    while (inflight || exp_q.size() != 0) @(posedge CLK);
    repeat (4) @(posedge CLK);
    if (!res_valid && cmd_ready) begin
      $display("** PASS **");
      $finish;
    end else begin
      stop_fail("unit not idle after the last command");
    end
  end

  // output monitor sampling on the rising edge
  initial begin
    result_t exp, prev_res;
    logic    stalled, illegal_due, first_pending;
    int      accept_cyc;
    stalled       = 1'b0;
    illegal_due   = 1'b0;
    first_pending = 1'b0;
    accept_cyc    = 0;
    prev_res      = '0;
    for (int r = 0; r < NUM_VREGS; r++) begin
      for (int e = 0; e < VLMAX; e++) begin
        mregs[r][e] = '0;
      end
    end
    wait (nRST);
    forever begin
      @(posedge CLK);
      if (stalled) begin
        assert (res_valid && res === prev_res) else stop_fail("stalled result beat changed");
      end
      if (inflight) begin
        assert (!cmd_ready) else stop_fail("cmd_ready high while a command is in progress");
      end
      check_value("illegal", 32'(illegal), 32'(illegal_due));
      illegal_due = 1'b0;
      if (first_pending && res_valid) begin
        check_value("first beat latency", 32'(cyc - accept_cyc), 32'd3);
        first_pending = 1'b0;
      end
      if (res_valid && res_ready) begin
        assert (exp_q.size() != 0) else stop_fail("result beat with no expected beat");
        exp = exp_q.pop_front();
        check_value("res.vd", 32'(res.vd), 32'(exp.vd));
        check_value("res.eidx", 32'(res.eidx), 32'(exp.eidx));
        check_value("res.wen0", 32'(res.wen0), 32'(exp.wen0));
        check_value("res.wen1", 32'(res.wen1), 32'(exp.wen1));
        check_value("res.last", 32'(res.last), 32'(exp.last));
        if (exp.wen0) begin
          check_value("res.data0", res.data0, exp.data0);
          mregs[exp.vd][exp.eidx] = exp.data0;
        end
        if (exp.wen1) begin
          check_value("res.data1", res.data1, exp.data1);
          mregs[exp.vd][exp.eidx + 1] = exp.data1;
        end
        if (exp.last) begin
          inflight = 1'b0;
        end
      end
      if (cmd_valid && cmd_ready) begin
        if (c_kind == K_BAD) begin
          illegal_due = 1'b1;
        end else begin
          predict_beats(c_kind, c_form, c_masked, c_vd, c_vs1, c_vs2, c_xs1, c_imm, c_vl);
          inflight      = 1'b1;
          first_pending = 1'b1;
          accept_cyc    = cyc;
        end
      end
      stalled  = res_valid && !res_ready;
      prev_res = res;
    end
  end

endmodule

// ==== vec_unit.f ====
+incdir+dv
src/vec_pkg.sv
src/vec_pipe_slot.sv
src/vec_instr_decoder.sv
src/vec_regfile.sv
src/vec_execute.sv
src/vec_result.sv
src/vec_decode_stage.sv
src/vec_unit.sv
dv/tb_clock.sv
dv/vec_unit_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 -f vec_unit.f --top-module vec_unit_tb -Mdir obj_dir
	./obj_dir/Vvec_unit_tb

clean:
	rm -rf obj_dir
